// ==== hdl/dcache_params.svh ====
/*
  dcache port controller widths and depths
  shared by the cache side and ring bus type packages
  and by the queue instances
*/
`ifndef DCACHE_PARAMS_SVH
`define DCACHE_PARAMS_SVH

`define DC_ADDR_W 37       // physical address
`define DC_REQ_W 5         // request id
`define DC_NODE_W 5        // ring node id
`define DC_SZ_W 5
`define DC_BANK_W 5
`define DC_LOW_W 2

`define DC_DATA_Q_DEPTH 16 // data read replay
`define DC_CODE_Q_DEPTH 8
`define DC_MISS_Q_DEPTH 24 // not a power of two
`define DC_REQ_IDS 32      // one table slot per request id

`define DC_BCAST_NODE 5'h1f // broadcast destination on the ring

`endif

// ==== hdl/dcache_pkg.sv ====
/*
  dcache port controller, cache side types
  queued data reads and misses, code fetches
  and the single insert port toward the cache arrays
*/
`include "dcache_params.svh"

package dcache_pkg;

  typedef struct packed {
    logic [`DC_ADDR_W-1:0] addr;
    logic [`DC_REQ_W-1:0]  req;
    logic                  dupl;
    logic                  want_excl;
    logic                  io;
    logic [`DC_SZ_W-1:0]   sz;
    logic [`DC_BANK_W-1:0] bank0;  // first bank touched
    logic [`DC_LOW_W-1:0]  low;
  } read_req_t;

  typedef struct packed {
    logic [`DC_ADDR_W-1:0] addr;
    logic [`DC_REQ_W-1:0]  req;
  } code_req_t;

  // who owns the insert port this cycle
  typedef enum logic [1:0] {
    INS_NONE  = 2'd0,
    INS_REPLY = 2'd1,
    INS_DATA  = 2'd2,
    INS_CODE  = 2'd3
  } insert_src_e;

  typedef struct packed {
    logic                  valid;
    insert_src_e           src;
    logic [`DC_ADDR_W-2:0] line_addr; // addr without bit 0
    logic                  odd;
    logic [`DC_REQ_W-1:0]  req;
    logic                  dupl;
    logic                  want_excl;
    logic                  second;    // second half of a reply
  } cache_port_t;

endpackage

// ==== hdl/rbus_pkg.sv ====
/*
  ring bus types
  outgoing miss requests and incoming memory replies
  with their opcode encodings
*/
`include "dcache_params.svh"

package rbus_pkg;

  typedef enum logic [1:0] {
    OP_MEM  = 2'd0,
    OP_IO   = 2'd1,
    OP_CODE = 2'd2
  } rbus_op_e;

  typedef enum logic {
    RPL_MEM = 1'b0,
    RPL_IO  = 1'b1
  } rbus_rpl_e;

  typedef struct packed {
    logic                   used;
    rbus_op_e               op;
    logic                   want_excl;
    logic                   dupl;
    logic [`DC_NODE_W-1:0]  src_node;
    logic [`DC_REQ_W-1:0]   src_req;
    logic [`DC_ADDR_W-1:0]  addr;
    logic [`DC_SZ_W-1:0]    sz;
    logic [`DC_BANK_W-1:0]  bank0;
    logic [`DC_LOW_W-1:0]   low;
  } rbus_req_t;

  typedef struct packed {
    logic                   used;
    rbus_rpl_e              kind;
    logic                   second;
    logic [`DC_NODE_W-1:0]  dst_node;
    logic [`DC_REQ_W-1:0]   dst_req;  // request id of the original miss
  } rbus_reply_t;

endpackage

// ==== hdl/req_fifo.sv ====
/*
  request queue
  circular buffer with wrapping pointers and an occupancy count,
  head read straight from storage
*/
`timescale 1ns/100ps

module req_fifo #(
  parameter int DEPTH = 16,
  parameter int WIDTH = 32
) (
  input  logic             clk,
  input  logic             rst,
  input  logic             push,
  input  logic [WIDTH-1:0] push_data,
  input  logic             pop,
  output logic [WIDTH-1:0] head,
  output logic             not_empty
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  logic [WIDTH-1:0] mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;

  // wrap at DEPTH-1 so odd depths work
  function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
    ptr_next = (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign head      = mem[rd_ptr];
  assign not_empty = (count != '0);

  always_ff @(posedge clk)
  begin
    if (push)
      mem[wr_ptr] <= push_data;
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (push)
        wr_ptr <= ptr_next(wr_ptr);
      if (pop && not_empty)
        rd_ptr <= ptr_next(rd_ptr);
      if (push && !(pop && not_empty))
        count <= count + 1'b1;
      else if (pop && not_empty && !push)
        count <= count - 1'b1; // push+pop leaves count as is
    end
  end

endmodule

// ==== hdl/miss_issue.sv ====
/*
  miss issue
  queues cache misses and sends them on the ring bus,
  one per cycle with want and can both high
*/
`timescale 1ns/100ps
`include "dcache_params.svh"

module miss_issue #(
  parameter logic [`DC_NODE_W-1:0] NODE_ID = '0
) (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  miss_push,
  input  dcache_pkg::read_req_t miss_in,
  input  logic                  rbus_can,
  output logic                  rbus_want,
  output rbus_pkg::rbus_req_t   rbus_req
);

  dcache_pkg::read_req_t head;
  logic                  xfer;

  assign xfer = rbus_want && rbus_can; // head leaves at the next edge

  req_fifo #(
    .DEPTH (`DC_MISS_Q_DEPTH),
    .WIDTH ($bits(dcache_pkg::read_req_t))
  ) u_miss_q (
    .clk       (clk),
    .rst       (rst),
    .push      (miss_push),
    .push_data (miss_in),
    .pop       (xfer),
    .head      (head),
    .not_empty (rbus_want)
  );

  always_comb
  begin
    rbus_req      = '0;
    rbus_req.used = xfer;
    if (rbus_want)
    begin
      if (head.io)
        rbus_req.op = rbus_pkg::OP_IO;
      else if (head.req[`DC_REQ_W-1] && !head.req[`DC_REQ_W-2])
        rbus_req.op = rbus_pkg::OP_CODE; // code fetch id range
      else
        rbus_req.op = rbus_pkg::OP_MEM;
      rbus_req.want_excl = head.want_excl;
      rbus_req.dupl      = head.dupl;
      rbus_req.src_node  = NODE_ID;
      rbus_req.src_req   = head.req;
      rbus_req.addr      = head.addr;
      rbus_req.sz        = head.sz;
      rbus_req.bank0     = head.bank0;
      rbus_req.low       = head.low;
    end
  end

endmodule

// ==== hdl/reply_capture.sv ====
/*
  reply capture
  keeps the address of every outstanding miss by request id,
  registers ring bus replies for one cycle and turns an
  accepted memory reply into a cache line insert
*/
`timescale 1ns/100ps
`include "dcache_params.svh"

module reply_capture #(
  parameter logic [`DC_NODE_W-1:0] NODE_ID = '0
) (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    miss_push,
  input  dcache_pkg::read_req_t   miss_in,
  input  rbus_pkg::rbus_reply_t   rbus_reply,
  output dcache_pkg::cache_port_t reply_ins
);

  logic [`DC_ADDR_W-1:0] tab_addr [`DC_REQ_IDS];
  logic                  tab_dupl [`DC_REQ_IDS];

  logic                  accept;
  logic                  acc_q;
  logic                  second_q;
  logic [`DC_REQ_W-1:0]  req_q;
  logic [`DC_ADDR_W-1:0] addr_q;
  logic                  dupl_q;

  assign accept = rbus_reply.used && (rbus_reply.kind == rbus_pkg::RPL_MEM) &&
                  (rbus_reply.dst_node == NODE_ID);

  // table write and reply lookup
  always_ff @(posedge clk)
  begin
    if (miss_push)
    begin
      tab_addr[miss_in.req] <= miss_in.addr;
      tab_dupl[miss_in.req] <= miss_in.dupl;
    end
    second_q <= rbus_reply.second;
    req_q    <= rbus_reply.dst_req;
    addr_q   <= tab_addr[rbus_reply.dst_req]; // old entry on same-edge write
    dupl_q   <= tab_dupl[rbus_reply.dst_req];
  end

  always_ff @(posedge clk)
  begin
    if (rst)
      acc_q <= 1'b0;
    else
      acc_q <= accept;
  end

  always_comb
  begin
    reply_ins           = '0;
    reply_ins.valid     = acc_q;
    reply_ins.src       = acc_q ? dcache_pkg::INS_REPLY : dcache_pkg::INS_NONE;
    reply_ins.line_addr = addr_q[`DC_ADDR_W-1:1];
    reply_ins.odd       = addr_q[0];
    reply_ins.req       = req_q;
    reply_ins.dupl      = dupl_q;
    reply_ins.second    = second_q;
  end

endmodule

// ==== hdl/insert_arbiter.sv ====
/*
  insert port arbiter
  fixed priority: reply insert, then data read replay,
  then code read; pops the queue that wins
*/
`timescale 1ns/100ps
`include "dcache_params.svh"

module insert_arbiter (
  input  dcache_pkg::cache_port_t reply_ins,
  input  dcache_pkg::read_req_t   data_head,
  input  logic                    data_ready,
  input  dcache_pkg::code_req_t   code_head,
  input  logic                    code_ready,
  output logic                    data_pop,
  output logic                    code_pop,
  output dcache_pkg::cache_port_t ins_port
);

  always_comb
  begin
    ins_port     = '0;
    ins_port.src = dcache_pkg::INS_NONE;
    data_pop     = 1'b0;
    code_pop     = 1'b0;

    if (reply_ins.valid)
    begin
      ins_port = reply_ins; // reply cannot wait
    end
    else if (data_ready)
    begin
      data_pop            = 1'b1;
      ins_port.valid      = 1'b1;
      ins_port.src        = dcache_pkg::INS_DATA;
      ins_port.line_addr  = data_head.addr[`DC_ADDR_W-1:1];
      ins_port.odd        = data_head.addr[0];
      ins_port.req        = data_head.req;
      ins_port.dupl       = data_head.dupl;
      ins_port.want_excl  = data_head.want_excl; // data reads only
    end
    else if (code_ready)
    begin
      code_pop            = 1'b1;
      ins_port.valid      = 1'b1;
      ins_port.src        = dcache_pkg::INS_CODE;
      ins_port.line_addr  = code_head.addr[`DC_ADDR_W-1:1];
      ins_port.odd        = code_head.addr[0];
      ins_port.req        = code_head.req;
    end
  end

endmodule

// ==== hdl/dcache_port_ctrl.sv ====
/*
  dcache port controller, request side
  data read replay queue, code read queue, miss issue to the
  ring bus and reply capture, all sharing one cache insert port
*/
`timescale 1ns/100ps
`include "dcache_params.svh"

module dcache_port_ctrl #(
  parameter logic [`DC_NODE_W-1:0] NODE_ID = '0
) (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    data_push,
  input  dcache_pkg::read_req_t   data_in,
  input  logic                    code_push,
  input  dcache_pkg::code_req_t   code_in,
  input  logic                    miss_push,
  input  dcache_pkg::read_req_t   miss_in,
  input  logic                    rbus_can,
  output logic                    rbus_want,
  output rbus_pkg::rbus_req_t     rbus_req,
  input  rbus_pkg::rbus_reply_t   rbus_reply,
  output dcache_pkg::cache_port_t ins_port
);

  dcache_pkg::read_req_t   data_head;
  dcache_pkg::code_req_t   code_head;
  dcache_pkg::cache_port_t reply_ins;
  logic                    data_ready;
  logic                    code_ready;
  logic                    data_pop;
  logic                    code_pop;

  req_fifo #(
    .DEPTH (`DC_DATA_Q_DEPTH),
    .WIDTH ($bits(dcache_pkg::read_req_t))
  ) u_data_q (
    .clk       (clk),
    .rst       (rst),
    .push      (data_push),
    .push_data (data_in),
    .pop       (data_pop),
    .head      (data_head),
    .not_empty (data_ready)
  );

  req_fifo #(
    .DEPTH (`DC_CODE_Q_DEPTH),
    .WIDTH ($bits(dcache_pkg::code_req_t))
  ) u_code_q (
    .clk       (clk),
    .rst       (rst),
    .push      (code_push),
    .push_data (code_in),
    .pop       (code_pop),
    .head      (code_head),
    .not_empty (code_ready)
  );

  miss_issue #(.NODE_ID(NODE_ID)) u_miss_issue (
    .clk       (clk),
    .rst       (rst),
    .miss_push (miss_push),
    .miss_in   (miss_in),
    .rbus_can  (rbus_can),
    .rbus_want (rbus_want),
    .rbus_req  (rbus_req)
  );

  // same miss stream feeds the id table
  reply_capture #(.NODE_ID(NODE_ID)) u_reply_capture (
    .clk        (clk),
    .rst        (rst),
    .miss_push  (miss_push),
    .miss_in    (miss_in),
    .rbus_reply (rbus_reply),
    .reply_ins  (reply_ins)
  );

  insert_arbiter u_insert_arbiter (
    .reply_ins  (reply_ins),
    .data_head  (data_head),
    .data_ready (data_ready),
    .code_head  (code_head),
    .code_ready (code_ready),
    .data_pop   (data_pop),
    .code_pop   (code_pop),
    .ins_port   (ins_port)
  );

endmodule

// ==== test/tb_dcache_port_ctrl.sv ====
/*
  testbench for the dcache port controller
  random pushes, ring bus grants and replies from a fixed seed,
  checked each cycle against a queue and table model
*/
`timescale 1ns/100ps
`include "dcache_params.svh"

module tb_dcache_port_ctrl;

  localparam logic [`DC_NODE_W-1:0] NODE_ID = 5'd3;
  localparam int TOTAL_CYCLES = 20 + 400 + 300 + 300 + 400 + 400 + 600 + 10;

  logic                    clk;
  logic                    rst;
  logic                    data_push;
  dcache_pkg::read_req_t   data_in;
  logic                    code_push;
  dcache_pkg::code_req_t   code_in;
  logic                    miss_push;
  dcache_pkg::read_req_t   miss_in;
  logic                    rbus_can;
  logic                    rbus_want;
  rbus_pkg::rbus_req_t     rbus_req;
  rbus_pkg::rbus_reply_t   rbus_reply;
  dcache_pkg::cache_port_t ins_port;

  integer seed;
  int     errors = 0;
  int     checks = 0;
  int     tests = 0;

  // model state
  dcache_pkg::read_req_t data_q [$];
  dcache_pkg::code_req_t code_q [$];
  dcache_pkg::read_req_t miss_q [$];
  logic [`DC_REQ_W-1:0]  id_list [$];
  logic [`DC_ADDR_W-1:0] tab_addr [`DC_REQ_IDS];
  logic                  tab_dupl [`DC_REQ_IDS];
  logic                  rpl_valid = 1'b0;
  logic [`DC_REQ_W-1:0]  rpl_req;
  logic                  rpl_second;
  logic [`DC_ADDR_W-1:0] rpl_addr;
  logic                  rpl_dupl;

  dcache_port_ctrl #(.NODE_ID(NODE_ID)) u_dut (
    .clk        (clk),
    .rst        (rst),
    .data_push  (data_push),
    .data_in    (data_in),
    .code_push  (code_push),
    .code_in    (code_in),
    .miss_push  (miss_push),
    .miss_in    (miss_in),
    .rbus_can   (rbus_can),
    .rbus_want  (rbus_want),
    .rbus_req   (rbus_req),
    .rbus_reply (rbus_reply),
    .ins_port   (ins_port)
  );

  initial clk = 1'b0;
  always #2 clk = ~clk;

  function automatic int pct();
    logic [31:0] r;
    r = $random(seed);
    pct = int'(r % 32'd100);
  endfunction

  function automatic dcache_pkg::read_req_t rand_read();
    dcache_pkg::read_req_t rq;
    logic [31:0] w0;
    logic [31:0] w1;
    w0 = $random(seed);
    w1 = $random(seed);
    rq.addr      = {w1[`DC_ADDR_W-33:0], w0};
    rq.req       = w1[9:5];
    rq.dupl      = w1[10];
    rq.want_excl = w1[11];
    rq.io        = (w1[14:12] == 3'd0); // rare
    rq.sz        = w1[20:16];
    rq.bank0     = w1[25:21];
    rq.low       = w1[27:26];
    return rq;
  endfunction

  function automatic dcache_pkg::code_req_t rand_code();
    dcache_pkg::read_req_t rq;
    dcache_pkg::code_req_t cq;
    rq      = rand_read();
    cq.addr = rq.addr;
    cq.req  = rq.req;
    return cq;
  endfunction

  task automatic check_port(input string name, input dcache_pkg::cache_port_t exp,
                            input dcache_pkg::cache_port_t act);
    checks++;
    if (act !== exp)
    begin
      errors++;
      $display("ERR %s ins_port at %0t expected %h actual %h", name, $time, exp, act);
    end
  endtask

  task automatic check_rbus(input string name, input rbus_pkg::rbus_req_t exp,
                            input rbus_pkg::rbus_req_t act);
    checks++;
    if (act !== exp)
    begin
      errors++;
      $display("ERR %s rbus_req at %0t expected %h actual %h", name, $time, exp, act);
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    checks++;
    if (act !== exp)
    begin
      errors++;
      $display("ERR %s rbus_want at %0t expected %b actual %b", name, $time, exp, act);
    end
  endtask

  task automatic drive_inputs(input int p_data, input int p_code, input int p_miss,
                              input int p_reply, input int p_can, input int reply_mode);
    logic [31:0]           r;
    logic [31:0]           r_idx;
    int                    idx;
    rbus_pkg::rbus_reply_t rp;
    data_in   = rand_read();
    data_push = (pct() < p_data) && (data_q.size() < `DC_DATA_Q_DEPTH);
    code_in   = rand_code();
    code_push = (pct() < p_code) && (code_q.size() < `DC_CODE_Q_DEPTH);
    miss_in   = rand_read();
    miss_push = (pct() < p_miss) && (miss_q.size() < `DC_MISS_Q_DEPTH);
    rbus_can  = (pct() < p_can);
    rp = '0;
    if (reply_mode != 0 && id_list.size() != 0 && pct() < p_reply)
    begin
      r          = $random(seed);
      r_idx      = $random(seed);
      idx        = int'(r_idx % 32'(id_list.size()));
      rp.used    = 1'b1;
      rp.kind    = rbus_pkg::RPL_MEM;
      rp.second  = r[31];
      rp.dst_node = NODE_ID;
      rp.dst_req = id_list[idx]; // only ids already sent as misses
      if (reply_mode == 2)
      begin
        rp.used = r[30] || r[29];
        rp.kind = (r[28] && r[27]) ? rbus_pkg::RPL_IO : rbus_pkg::RPL_MEM;
        case (r[26:25])
          2'd0:    rp.dst_node = r[24:20];
          2'd1:    rp.dst_node = `DC_BCAST_NODE;
          default: rp.dst_node = NODE_ID;
        endcase
      end
    end
    rbus_reply = rp;
  endtask

  task automatic predict_and_check(input string name);
    dcache_pkg::cache_port_t exp_port;
    rbus_pkg::rbus_req_t     exp_req;
    dcache_pkg::read_req_t   m;
    exp_port = '0;
    if (rpl_valid)
    begin
      exp_port.valid     = 1'b1;
      exp_port.src       = dcache_pkg::INS_REPLY;
      exp_port.line_addr = rpl_addr[`DC_ADDR_W-1:1];
      exp_port.odd       = rpl_addr[0];
      exp_port.req       = rpl_req;
      exp_port.dupl      = rpl_dupl;
      exp_port.second    = rpl_second;
    end
    else if (data_q.size() != 0)
    begin
      exp_port.valid     = 1'b1;
      exp_port.src       = dcache_pkg::INS_DATA;
      exp_port.line_addr = data_q[0].addr[`DC_ADDR_W-1:1];
      exp_port.odd       = data_q[0].addr[0];
      exp_port.req       = data_q[0].req;
      exp_port.dupl      = data_q[0].dupl;
      exp_port.want_excl = data_q[0].want_excl;
    end
    else if (code_q.size() != 0)
    begin
      exp_port.valid     = 1'b1;
      exp_port.src       = dcache_pkg::INS_CODE;
      exp_port.line_addr = code_q[0].addr[`DC_ADDR_W-1:1];
      exp_port.odd       = code_q[0].addr[0];
      exp_port.req       = code_q[0].req;
    end
    exp_req = '0;
    if (miss_q.size() != 0)
    begin
      m = miss_q[0];
      exp_req.used = rbus_can;
      if (m.io)
        exp_req.op = rbus_pkg::OP_IO;
      else if (m.req[4] && !m.req[3])
        exp_req.op = rbus_pkg::OP_CODE;
      else
        exp_req.op = rbus_pkg::OP_MEM;
      exp_req.want_excl = m.want_excl;
      exp_req.dupl      = m.dupl;
      exp_req.src_node  = NODE_ID;
      exp_req.src_req   = m.req;
      exp_req.addr      = m.addr;
      exp_req.sz        = m.sz;
      exp_req.bank0     = m.bank0;
      exp_req.low       = m.low;
    end
    check_port(name, exp_port, ins_port);
    check_bit(name, miss_q.size() != 0, rbus_want);
    check_rbus(name, exp_req, rbus_req);
  endtask

  // state change at the coming edge
  task automatic model_step();
    if (!rpl_valid)
    begin
      if (data_q.size() != 0)
        data_q.delete(0);
      else if (code_q.size() != 0)
        code_q.delete(0);
    end
    if (miss_q.size() != 0 && rbus_can)
      miss_q.delete(0);
    rpl_valid  = rbus_reply.used && (rbus_reply.kind == rbus_pkg::RPL_MEM) &&
                 (rbus_reply.dst_node == NODE_ID);
    rpl_req    = rbus_reply.dst_req;
    rpl_second = rbus_reply.second;
    rpl_addr   = tab_addr[rbus_reply.dst_req]; // entry as it was before this edge
    rpl_dupl   = tab_dupl[rbus_reply.dst_req];
    if (miss_push)
    begin
      tab_addr[miss_in.req] = miss_in.addr;
      tab_dupl[miss_in.req] = miss_in.dupl;
      id_list.push_back(miss_in.req);
      miss_q.push_back(miss_in);
    end
    if (data_push)
      data_q.push_back(data_in);
    if (code_push)
      code_q.push_back(code_in);
  endtask

  task automatic run_test(input string name, input int cycles, input int p_data,
                          input int p_code, input int p_miss, input int p_reply,
                          input int p_can, input int reply_mode);
    int err_start;
    err_start = errors;
    for (int i = 0; i < cycles; i++)
    begin
      @(posedge clk);
      #1;
      drive_inputs(p_data, p_code, p_miss, p_reply, p_can, reply_mode);
      #2;
      predict_and_check(name);
      model_step();
    end
    tests++;
    $display("%-14s %0d cycles, %0d errors", name, cycles, errors - err_start);
  endtask

  initial
  begin
    #(TOTAL_CYCLES * 4 * 2);
    $display("watchdog expired, the tests did not finish in time");
    $display("TEST FAILED");
    $finish;
  end

  initial
  begin
    seed       = 32'h67a1_37c8;
    rst        = 1'b1;
    data_push  = 1'b0;
    data_in    = '0;
    code_push  = 1'b0;
    code_in    = '0;
    miss_push  = 1'b0;
    miss_in    = '0;
    rbus_can   = 1'b0;
    rbus_reply = '0;
    repeat (3) @(posedge clk);
    #1;
    rst = 1'b0;

    run_test("reset_idle", 20, 0, 0, 0, 0, 50, 0);
    run_test("miss_issue", 400, 0, 0, 40, 0, 50, 0);
    run_test("data_reads", 300, 40, 0, 0, 0, 50, 0);
    run_test("code_reads", 300, 15, 40, 0, 0, 50, 0);
    run_test("reply_insert", 400, 30, 30, 30, 40, 60, 1);
    run_test("reply_filter", 400, 30, 30, 30, 50, 60, 2);
    run_test("mixed", 600, 35, 25, 35, 35, 70, 2);

    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0)
      $display("TEST OK");
    else
      $display("TEST FAILED");
    $finish;
  end

endmodule

// ==== vlog.f ====
+incdir+hdl
hdl/dcache_pkg.sv
hdl/rbus_pkg.sv
hdl/req_fifo.sv
hdl/miss_issue.sv
hdl/reply_capture.sv
hdl/insert_arbiter.sv
hdl/dcache_port_ctrl.sv
test/tb_dcache_port_ctrl.sv

// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing -j 0
TOP      = tb_dcache_port_ctrl
FILELIST = vlog.f
LOG      = sim.log

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "TEST OK" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
